// ==== rtl/video_pkg.sv ====
`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int h_active = 64;
    localparam int h_front  = 4;
    localparam int h_sync   = 8;
    localparam int h_total  = 80;

    localparam int v_active = 48;
    localparam int v_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_total  = 56;

    ////////////////////////////////////////////////////////////////////////////
    // Memory and layer sizes
    ////////////////////////////////////////////////////////////////////////////
    // Cell and sprite edge, also the border width
    localparam int cell_px     = 8;
    localparam int text_cols   = 8;
    localparam int text_rows   = 6;
    localparam int text_cells  = text_cols * text_rows;
    localparam int glyph_count = 16;
    localparam int num_sprites = 4;
    localparam int pal_depth   = 16;

    typedef logic [6:0]  hpos_t;
    typedef logic [5:0]  vline_t;
    typedef logic [3:0]  colidx_t;
    // Red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb_t;
    // Glyph in [11:8], foreground in [7:4], background in [3:0]
    typedef logic [11:0] cell_t;
    typedef logic [7:0]  spr_row_t;

    typedef enum logic [1:0] {
        spr_idle,
        spr_armed,
        spr_draw
    } spr_state_t;

    typedef enum logic [1:0] {
        layer_back,
        layer_text,
        layer_sprite
    } layer_t;

endpackage

`default_nettype wire

// ==== rtl/video_timing.sv ====
`default_nettype none
`timescale 1ns/10ps

module video_timing (
    input  wire                    vclk,
    input  wire                    rst,
    input  wire video_pkg::vline_t reg_irqline,
    output video_pkg::hpos_t       hpos,
    output video_pkg::vline_t      vline,
    output logic                   hblank,
    output logic                   vblank,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   line_start,
    output logic                   irq_line,
    output logic                   irq_vblank
);
    import video_pkg::*;

    logic line_match;
    logic q_line_match;
    logic q_vblank;

    // Pixel and line counters
    always_ff @(posedge vclk) begin
        if (rst) begin
            hpos  <= '0;
            vline <= '0;
        end else if (hpos == hpos_t'(h_total - 1)) begin
            hpos <= '0;
            if (vline == vline_t'(v_total - 1))
                vline <= '0;
            else
                vline <= vline + 1'b1;
        end else begin
            hpos <= hpos + 1'b1;
        end
    end

    assign hblank = hpos >= hpos_t'(h_active);
    assign hsync  = (hpos >= hpos_t'(h_active + h_front)) &&
                    (hpos <  hpos_t'(h_active + h_front + h_sync));
    assign vblank = vline >= vline_t'(v_active);
    assign vsync  = (vline >= vline_t'(v_active + v_front)) &&
                    (vline <  vline_t'(v_active + v_front + v_sync));

    // Start of the active part of every line
    assign line_start = hpos == '0;

    assign line_match = vline == reg_irqline;

    // Interrupts fire on the rising edge of each condition
    always_ff @(posedge vclk) begin
        if (rst) begin
            q_line_match <= 1'b0;
            q_vblank     <= 1'b0;
            irq_line     <= 1'b0;
            irq_vblank   <= 1'b0;
        end else begin
            q_line_match <= line_match;
            q_vblank     <= vblank;
            irq_line     <= line_match && !q_line_match;
            irq_vblank   <= vblank && !q_vblank;
        end
    end

    // Sync pulse sits inside the front porch boundaries of the blank
    assert property (@(posedge vclk) disable iff (rst) hsync |-> hblank);

endmodule

`default_nettype wire

// ==== rtl/text_layer.sv ====
`default_nettype none
`timescale 1ns/10ps

module text_layer (
    input  wire                      vclk,
    input  wire                      rst,
    input  wire video_pkg::hpos_t    hpos,
    input  wire video_pkg::vline_t   vline,
    input  wire                      tram_wren,
    input  wire [5:0]                tram_addr,
    input  wire video_pkg::cell_t    tram_wrdata,
    input  wire                      gram_wren,
    input  wire [6:0]                gram_addr,
    input  wire video_pkg::spr_row_t gram_wrdata,
    output video_pkg::colidx_t       text_colidx,
    output logic                     text_fg_hit
);
    import video_pkg::*;

    cell_t    tram [text_cells];
    spr_row_t gram [glyph_count * cell_px];

    logic [5:0] cell_addr;
    logic [6:0] glyph_addr;

    // Stage 1: cell word plus pixel position within the cell
    cell_t      q_cell;
    logic [2:0] q1_px;
    logic [2:0] q1_row;

    // Stage 2: glyph byte and cell colours
    spr_row_t   q_glyph;
    logic [2:0] q2_px;
    colidx_t    q2_fg;
    colidx_t    q2_bg;

    ////////////////////////////////////////////////////////////////////////////
    // Host writes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge vclk) begin
        if (tram_wren)
            tram[tram_addr] <= tram_wrdata;
    end

    always_ff @(posedge vclk) begin
        if (gram_wren)
            gram[gram_addr] <= gram_wrdata;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cell address walk and glyph fetch
    ////////////////////////////////////////////////////////////////////////////
    assign cell_addr = 6'(vline[5:3] * text_cols) + 6'(hpos[5:3]);

    always_ff @(posedge vclk) begin
        if (rst) begin
            q_cell <= '0;
            q1_px  <= '0;
            q1_row <= '0;
        end else begin
            // Rows past the last text row only occur in vblank
            if (cell_addr < 6'(text_cells))
                q_cell <= tram[cell_addr];
            else
                q_cell <= '0;
            q1_px  <= hpos[2:0];
            q1_row <= vline[2:0];
        end
    end

    assign glyph_addr = {q_cell[11:8], q1_row};

    always_ff @(posedge vclk) begin
        if (rst) begin
            q2_px <= '0;
            q2_fg <= '0;
            q2_bg <= '0;
        end else begin
            q2_px <= q1_px;
            q2_fg <= q_cell[7:4];
            q2_bg <= q_cell[3:0];
        end
    end

    always_ff @(posedge vclk) begin
        q_glyph <= gram[glyph_addr];
    end

    // Leftmost pixel is the glyph MSB
    assign text_fg_hit = q_glyph[3'd7 - q2_px];
    assign text_colidx = text_fg_hit ? q2_fg : q2_bg;

endmodule

`default_nettype wire

// ==== rtl/sprite_store.sv ====
`default_nettype none
`timescale 1ns/10ps

module sprite_store (
    input  wire                      vclk,
    input  wire                      rst,
    input  wire                      spr_wren,
    input  wire [5:0]                spr_addr,
    input  wire [7:0]                spr_wrdata,
    input  wire                      line_start,
    input  wire video_pkg::vline_t   vline,
    output logic [video_pkg::num_sprites-1:0] load,
    output video_pkg::spr_row_t      row_bits [video_pkg::num_sprites],
    output video_pkg::hpos_t         x_start [video_pkg::num_sprites],
    output video_pkg::colidx_t       spr_colidx [video_pkg::num_sprites]
);
    import video_pkg::*;

    hpos_t    x_pos   [num_sprites];
    vline_t   y_pos   [num_sprites];
    colidx_t  colour  [num_sprites];
    spr_row_t pattern [num_sprites][cell_px];
    logic [num_sprites-1:0] enable;

    logic [1:0] wr_sel;
    logic [3:0] wr_word;
    logic       v_border;
    logic [num_sprites-1:0] on_line;
    logic [2:0] spr_dy [num_sprites];

    // Word 0 x, 1 y, 2 colour, 3 enable, 4 to 11 pattern rows
    assign wr_sel  = spr_addr[5:4];
    assign wr_word = spr_addr[3:0];

    always_ff @(posedge vclk) begin
        if (rst)
            enable <= '0;
        else if (spr_wren && wr_word == 4'd3)
            enable[wr_sel] <= spr_wrdata[0];
    end

    always_ff @(posedge vclk) begin
        if (spr_wren) begin
            case (wr_word)
                4'd0: x_pos[wr_sel]  <= spr_wrdata[6:0];
                4'd1: y_pos[wr_sel]  <= spr_wrdata[5:0];
                4'd2: colour[wr_sel] <= spr_wrdata[3:0];
                4'd3: ;
                default: begin
                    if (wr_word < 4'd12)
                        pattern[wr_sel][3'(wr_word - 4'd4)] <= spr_wrdata;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-line row selection
    ////////////////////////////////////////////////////////////////////////////
    assign v_border = (vline < vline_t'(cell_px)) ||
                      (vline >= vline_t'(v_active - cell_px));

    always_comb begin
        for (int i = 0; i < num_sprites; i++) begin
            spr_dy[i]  = 3'(vline - y_pos[i]);
            on_line[i] = enable[i] && !v_border && (vline >= y_pos[i]) &&
                         ({1'b0, vline} < {1'b0, y_pos[i]} + 7'(cell_px));
        end
    end

    always_ff @(posedge vclk) begin
        if (rst)
            load <= '0;
        else
            load <= {num_sprites{line_start}};
    end

    // Engines get their row for the line that is just starting
    always_ff @(posedge vclk) begin
        if (line_start) begin
            for (int i = 0; i < num_sprites; i++) begin
                row_bits[i]   <= on_line[i] ? pattern[i][spr_dy[i]] : '0;
                x_start[i]    <= x_pos[i];
                spr_colidx[i] <= colour[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sprite_engine.sv ====
`default_nettype none
`timescale 1ns/10ps

module sprite_engine (
    input  wire                      vclk,
    input  wire                      rst,
    input  wire                      load,
    input  wire video_pkg::spr_row_t row_bits,
    input  wire video_pkg::hpos_t    x_start,
    input  wire video_pkg::colidx_t  spr_colidx,
    input  wire video_pkg::hpos_t    hpos,
    output logic                     hit,
    output video_pkg::colidx_t       colidx
);
    import video_pkg::*;

    spr_state_t state;
    spr_row_t   shreg;
    logic [2:0] cnt;
    logic       start;
    logic       h_border;

    assign start    = (state == spr_armed) && (hpos == x_start);
    assign h_border = (hpos < hpos_t'(cell_px)) ||
                      (hpos >= hpos_t'(h_active - cell_px));

    // Line FSM, one pixel out per clock once x matches
    always_ff @(posedge vclk) begin
        if (rst) begin
            state <= spr_idle;
            cnt   <= '0;
            hit   <= 1'b0;
        end else begin
            hit <= 1'b0;
            if (load) begin
                state <= spr_armed;
            end else begin
                case (state)
                    spr_idle: ;
                    spr_armed: begin
                        if (start) begin
                            state <= spr_draw;
                            cnt   <= 3'd1;
                            hit   <= shreg[7] && !h_border;
                        end
                    end
                    spr_draw: begin
                        hit <= shreg[7] && !h_border;
                        cnt <= cnt + 3'd1;
                        // Eighth bit leaves on this clock
                        if (cnt == 3'd7)
                            state <= spr_idle;
                    end
                    default: state <= spr_idle;
                endcase
            end
        end
    end

    always_ff @(posedge vclk) begin
        if (load) begin
            shreg  <= row_bits;
            colidx <= spr_colidx;
        end else if (start || state == spr_draw) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

    // Drawing always passes through the armed state
    assert property (@(posedge vclk) disable iff (rst)
        state == spr_idle |=> state != spr_draw);

endmodule

`default_nettype wire

// ==== rtl/compositor.sv ====
`default_nettype none
`timescale 1ns/10ps

module compositor (
    input  wire                     vclk,
    input  wire                     rst,
    input  wire [video_pkg::num_sprites-1:0] hit,
    input  wire video_pkg::colidx_t colidx [video_pkg::num_sprites],
    input  wire video_pkg::colidx_t text_colidx,
    input  wire                     text_fg_hit,
    input  wire                     hblank,
    input  wire                     vblank,
    input  wire                     hsync,
    input  wire                     vsync,
    input  wire                     reg_text_enable,
    input  wire                     reg_sprites_enable,
    input  wire                     reg_text_priority,
    input  wire                     pal_wren,
    input  wire video_pkg::colidx_t pal_addr,
    input  wire video_pkg::rgb_t    pal_wrdata,
    output video_pkg::rgb_t         video_rgb,
    output logic                    video_de,
    output logic                    video_hsync,
    output logic                    video_vsync
);
    import video_pkg::*;

    rgb_t pal [pal_depth];

    logic    spr_hit;
    colidx_t spr_idx;
    logic    q_spr_hit;
    colidx_t q_spr_idx;

    // Blank, hsync and vsync delayed to match the pixel pipe
    logic [2:0] q1_ctl;
    logic [2:0] q2_ctl;

    layer_t  layer;
    colidx_t pix_idx;

    always_ff @(posedge vclk) begin
        if (pal_wren)
            pal[pal_addr] <= pal_wrdata;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sprite resolve, lowest index on top
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        spr_hit = 1'b0;
        spr_idx = '0;
        for (int i = num_sprites - 1; i >= 0; i--) begin
            if (hit[i]) begin
                spr_hit = 1'b1;
                spr_idx = colidx[i];
            end
        end
    end

    always_ff @(posedge vclk) begin
        if (rst) begin
            q_spr_hit <= 1'b0;
            q_spr_idx <= '0;
            // Blanked until the first counter value reaches the output
            q1_ctl    <= 3'b100;
            q2_ctl    <= 3'b100;
        end else begin
            q_spr_hit <= spr_hit;
            q_spr_idx <= spr_idx;
            q1_ctl    <= {hblank || vblank, hsync, vsync};
            q2_ctl    <= q1_ctl;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Layer merge and palette lookup
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        layer = layer_back;
        if (reg_text_enable)
            layer = layer_text;
        if (reg_sprites_enable && q_spr_hit &&
            !(reg_text_enable && reg_text_priority && text_fg_hit))
            layer = layer_sprite;

        case (layer)
            layer_text:   pix_idx = text_colidx;
            layer_sprite: pix_idx = q_spr_idx;
            default:      pix_idx = '0;
        endcase
    end

    always_ff @(posedge vclk) begin
        if (rst) begin
            video_rgb   <= '0;
            video_de    <= 1'b0;
            video_hsync <= 1'b0;
            video_vsync <= 1'b0;
        end else begin
            video_hsync <= q2_ctl[1];
            video_vsync <= q2_ctl[0];
            if (q2_ctl[2]) begin
                video_rgb <= '0;
                video_de  <= 1'b0;
            end else begin
                video_rgb <= pal[pix_idx];
                video_de  <= 1'b1;
            end
        end
    end

    // Output enable trails the counter blanking by exactly three clocks
    assert property (@(posedge vclk) disable iff (rst)
        $past(hblank || vblank, 3) |-> !video_de);

endmodule

`default_nettype wire

// ==== rtl/video.sv ====
`default_nettype none
`timescale 1ns/10ps

module video (
    input  wire                      vclk,
    input  wire                      rst,
    // Text and glyph RAM writes
    input  wire                      tram_wren,
    input  wire [5:0]                tram_addr,
    input  wire video_pkg::cell_t    tram_wrdata,
    input  wire                      gram_wren,
    input  wire [6:0]                gram_addr,
    input  wire video_pkg::spr_row_t gram_wrdata,
    // Sprite store and palette writes
    input  wire                      spr_wren,
    input  wire [5:0]                spr_addr,
    input  wire [7:0]                spr_wrdata,
    input  wire                      pal_wren,
    input  wire video_pkg::colidx_t  pal_addr,
    input  wire video_pkg::rgb_t     pal_wrdata,
    // Control registers
    input  wire                      reg_text_enable,
    input  wire                      reg_sprites_enable,
    input  wire                      reg_text_priority,
    input  wire video_pkg::vline_t   reg_irqline,
    output video_pkg::rgb_t          video_rgb,
    output logic                     video_de,
    output logic                     video_hsync,
    output logic                     video_vsync,
    output video_pkg::vline_t        vline,
    output logic                     irq_line,
    output logic                     irq_vblank
);
    import video_pkg::*;

    hpos_t hpos;
    logic  hblank, vblank, hsync, vsync, line_start;

    colidx_t text_colidx;
    logic    text_fg_hit;

    logic [num_sprites-1:0] spr_load;
    spr_row_t spr_row [num_sprites];
    hpos_t    spr_x   [num_sprites];
    colidx_t  spr_col [num_sprites];

    logic [num_sprites-1:0] eng_hit;
    colidx_t eng_colidx [num_sprites];

    video_timing timing0 (
        .vclk, .rst, .reg_irqline, .hpos, .vline, .hblank, .vblank,
        .hsync, .vsync, .line_start, .irq_line, .irq_vblank
    );

    text_layer text0 (
        .vclk, .rst, .hpos, .vline,
        .tram_wren, .tram_addr, .tram_wrdata,
        .gram_wren, .gram_addr, .gram_wrdata,
        .text_colidx, .text_fg_hit
    );

    sprite_store store0 (
        .vclk, .rst, .spr_wren, .spr_addr, .spr_wrdata, .line_start, .vline,
        .load(spr_load), .row_bits(spr_row), .x_start(spr_x), .spr_colidx(spr_col)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Sprite engines
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < num_sprites; i++) begin : g_engine
        sprite_engine engine (
            .vclk, .rst, .load(spr_load[i]), .row_bits(spr_row[i]),
            .x_start(spr_x[i]), .spr_colidx(spr_col[i]), .hpos,
            .hit(eng_hit[i]), .colidx(eng_colidx[i])
        );
    end

    compositor comp0 (
        .vclk, .rst, .hit(eng_hit), .colidx(eng_colidx),
        .text_colidx, .text_fg_hit, .hblank, .vblank, .hsync, .vsync,
        .reg_text_enable, .reg_sprites_enable, .reg_text_priority,
        .pal_wren, .pal_addr, .pal_wrdata,
        .video_rgb, .video_de, .video_hsync, .video_vsync
    );

endmodule

`default_nettype wire

// ==== test/video_checks.svh ====
`ifndef VIDEO_CHECKS_SVH
`define VIDEO_CHECKS_SVH

// ANSI C style LCG, 32-bit wrap
function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp) begin
        $display("error %s got 0x%03h expected 0x%03h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_vline(input string name, input vline_t got, input vline_t exp);
    if (got !== exp) begin
        $display("error %s got 0x%02h expected 0x%02h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
        $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    end
endtask

`endif

// ==== test/video_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module video_tb;
    import video_pkg::*;

    localparam int clk_half   = 50;
    localparam int frame_clks = v_total * h_total;
    localparam int npix       = h_active * v_active;

    logic              vclk;
    logic              rst;
    logic              tram_wren;
    logic [5:0]        tram_addr;
    cell_t             tram_wrdata;
    logic              gram_wren;
    logic [6:0]        gram_addr;
    spr_row_t          gram_wrdata;
    logic              spr_wren;
    logic [5:0]        spr_addr;
    logic [7:0]        spr_wrdata;
    logic              pal_wren;
    colidx_t           pal_addr;
    rgb_t              pal_wrdata;
    logic              reg_text_enable;
    logic              reg_sprites_enable;
    logic              reg_text_priority;
    vline_t            reg_irqline;
    rgb_t              video_rgb;
    logic              video_de;
    logic              video_hsync;
    logic              video_vsync;
    vline_t            vline;
    logic              irq_line;
    logic              irq_vblank;

    // Reference copies of the host-written memories
    cell_t    tram_m [text_cells];
    spr_row_t gram_m [glyph_count * cell_px];
    rgb_t     pal_m  [pal_depth];

    rgb_t frame_rgb [npix];
    rgb_t exp_rgb   [npix];

    string       recs [$];
    int          ex_x [$];
    int          ex_y [$];
    int          ex_n [$];
    rgb_t        ex_rgb [$];
    int          irq_exp [$];
    int          n_frames;
    int unsigned rng;
    bit          filled;
    bit          in_window;

    video dut0 (.*);

    initial vclk = 1'b0;
    always #clk_half vclk = ~vclk;

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    `include "video_checks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////////////////////
    task automatic host_write(input logic [7:0] kind, input int addr, input int data);
        if (kind == "R") begin
            case (addr)
                0: reg_text_enable = data[0];
                1: reg_sprites_enable = data[0];
                2: reg_text_priority = data[0];
                default: reg_irqline = vline_t'(data);
            endcase
        end else begin
            case (kind)
                "T": begin
                    tram_wren   = 1'b1;
                    tram_addr   = 6'(addr);
                    tram_wrdata = cell_t'(data);
                    tram_m[addr] = cell_t'(data);
                end
                "G": begin
                    gram_wren   = 1'b1;
                    gram_addr   = 7'(addr);
                    gram_wrdata = spr_row_t'(data);
                    gram_m[addr] = spr_row_t'(data);
                end
                "S": begin
                    spr_wren   = 1'b1;
                    spr_addr   = 6'(addr);
                    spr_wrdata = 8'(data);
                end
                default: begin
                    pal_wren   = 1'b1;
                    pal_addr   = colidx_t'(addr);
                    pal_wrdata = rgb_t'(data);
                    pal_m[addr] = rgb_t'(data);
                end
            endcase
            @(negedge vclk);
            tram_wren = 1'b0;
            gram_wren = 1'b0;
            spr_wren  = 1'b0;
            pal_wren  = 1'b0;
        end
    endtask

    // Random text, glyphs and palette, sprites cleared
    task automatic fill_memories();
        for (int i = 0; i < text_cells; i++) begin
            rng = lcg_next(rng);
            host_write("T", i, int'(rng[27:16]));
        end
        for (int i = 0; i < glyph_count * cell_px; i++) begin
            rng = lcg_next(rng);
            host_write("G", i, int'(rng[23:16]));
        end
        for (int i = 0; i < pal_depth; i++) begin
            rng = lcg_next(rng);
            host_write("P", i, int'(rng[27:16]));
        end
        for (int s = 0; s < num_sprites; s++)
            for (int w = 0; w < 12; w++)
                host_write("S", s * 16 + w, 0);
    endtask

    task automatic enter_vblank();
        while (vline != vline_t'(v_active))
            @(negedge vclk);
        if (!filled)
            fill_memories();
        filled    = 1'b1;
        in_window = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frame capture and compare
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_frame();
        int     x;
        int     y;
        int     pixels;
        int     hs_edges;
        int     vs_edges;
        int     irq_l;
        int     irq_v;
        vline_t irq_at;
        logic   prev_de;
        logic   prev_hs;
        logic   prev_vs;
        cell_t    c;
        spr_row_t g;
        colidx_t  idx;

        while (vline != '0)
            @(negedge vclk);
        x = 0;
        y = -1;
        pixels = 0;
        hs_edges = 0;
        vs_edges = 0;
        irq_l = 0;
        irq_v = 0;
        irq_at = '0;
        prev_de = video_de;
        prev_hs = video_hsync;
        prev_vs = video_vsync;
        repeat (frame_clks) begin
            if (video_de && !prev_de) begin
                y++;
                x = 0;
            end
            if (!video_de && prev_de)
                check_count("video_de pixels per line", x, h_active);
            if (video_de) begin
                if (y < 0 || y >= v_active || x >= h_active) begin
                    $display("video_de is high outside the 64 by 48 active area");
                    abort_run();
                end
                frame_rgb[y * h_active + x] = video_rgb;
                x++;
                pixels++;
            end
            if (video_hsync && !prev_hs)
                hs_edges++;
            if (video_vsync && !prev_vs)
                vs_edges++;
            if (irq_line) begin
                irq_l++;
                irq_at = vline;
            end
            if (irq_vblank)
                irq_v++;
            prev_de = video_de;
            prev_hs = video_hsync;
            prev_vs = video_vsync;
            @(negedge vclk);
        end
        check_count("video_de lines", y + 1, v_active);
        check_count("video_de pixels", pixels, npix);
        check_count("video_hsync pulses", hs_edges, v_total);
        check_count("video_vsync pulses", vs_edges, 1);
        check_count("irq_vblank pulses", irq_v, 1);
        if (irq_exp.size() > 0) begin
            check_count("irq_line pulses", irq_l, 1);
            check_vline("vline at irq_line", irq_at, vline_t'(irq_exp[0]));
        end

        // Text rule for every pixel, sprite runs from the file on top
        for (int yy = 0; yy < v_active; yy++) begin
            for (int xx = 0; xx < h_active; xx++) begin
                c = tram_m[(yy / cell_px) * text_cols + xx / cell_px];
                g = gram_m[int'(c[11:8]) * cell_px + yy % cell_px];
                idx = g[7 - xx % cell_px] ? c[7:4] : c[3:0];
                if (!reg_text_enable)
                    idx = '0;
                exp_rgb[yy * h_active + xx] = pal_m[idx];
            end
        end
        foreach (ex_x[k])
            for (int j = 0; j < ex_n[k]; j++)
                exp_rgb[ex_y[k] * h_active + ex_x[k] + j] = ex_rgb[k];
        for (int p = 0; p < npix; p++)
            check_rgb($sformatf("video_rgb x %0d y %0d", p % h_active, p / h_active),
                      frame_rgb[p], exp_rgb[p]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        int          a;
        int          b;
        int          c;
        int          d;
        int          first_run;
        longint      limit;

        rst = 1'b1;
        tram_wren = 1'b0;
        tram_addr = '0;
        tram_wrdata = '0;
        gram_wren = 1'b0;
        gram_addr = '0;
        gram_wrdata = '0;
        spr_wren = 1'b0;
        spr_addr = '0;
        spr_wrdata = '0;
        pal_wren = 1'b0;
        pal_addr = '0;
        pal_wrdata = '0;
        reg_text_enable = 1'b0;
        reg_sprites_enable = 1'b0;
        reg_text_priority = 1'b0;
        reg_irqline = '0;
        rng = 43;
        filled = 1'b0;
        in_window = 1'b0;
        n_frames = 0;

        fd = $fopen("test/video_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/video_stimulus.txt");
            abort_run();
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
                recs.push_back(line);
                if (line[0] == "F")
                    n_frames++;
            end
        end
        $fclose(fd);

        // Two frames of waiting per captured frame, plus start-up
        limit = longint'(2 * n_frames + 2) * frame_clks * 2 * clk_half * 2;
        fork
            begin
                #(limit);
                $display("timeout, the run did not finish in time");
                abort_run();
            end
        join_none

        repeat (3) @(negedge vclk);
        rst = 1'b0;
        check_flag("video_de after reset", video_de, 1'b0);
        check_flag("video_hsync after reset", video_hsync, 1'b0);
        check_flag("video_vsync after reset", video_vsync, 1'b0);
        check_flag("irq_line after reset", irq_line, 1'b0);
        check_flag("irq_vblank after reset", irq_vblank, 1'b0);
        check_rgb("video_rgb after reset", video_rgb, '0);

        // First line after reset holds exactly one line of de pixels
        while (!video_de)
            @(negedge vclk);
        first_run = 0;
        while (video_de) begin
            first_run++;
            @(negedge vclk);
        end
        check_count("video_de pixels on the first line", first_run, h_active);

        foreach (recs[r]) begin
            a = 0;
            b = 0;
            c = 0;
            d = 0;
            void'($sscanf(recs[r], "%c %h %h %h %h", op, a, b, c, d));
            case (op)
                "E": begin
                    ex_x.push_back(a);
                    ex_y.push_back(b);
                    ex_n.push_back(c);
                    ex_rgb.push_back(rgb_t'(d));
                end
                "I": irq_exp.push_back(a);
                "F": begin
                    if (!in_window)
                        enter_vblank();
                    run_frame();
                    ex_x.delete();
                    ex_y.delete();
                    ex_n.delete();
                    ex_rgb.delete();
                    irq_exp.delete();
                    in_window = 1'b0;
                end
                default: begin
                    if (!in_window)
                        enter_vblank();
                    host_write(op, a, b);
                end
            endcase
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/video_stimulus.txt ====
# T/G/S/P addr data: text, glyph, sprite, palette write. R reg data: 0 text, 1 sprites, 2 prio, 3 irq
# E x y count rgb: expected pixel run. I line: expected irq line. F: capture a frame. Hex fields
R 0 1
R 1 1
R 2 0
R 3 14
P 0 123
P 1 f00
P 2 0f0
P 3 00f
P 4 ff0
P 5 0ff
P 6 f0f
T 12 f56
T 13 e56
T 16 e56
T 0c e56
G 78 f0
G 70 00
G 71 00
G 74 00
S 00 10
S 01 10
S 02 1
S 04 ff
S 03 1
S 10 14
S 11 10
S 12 2
S 14 ff
S 13 1
S 20 34
S 21 14
S 22 3
S 24 ff
S 23 1
S 30 20
S 31 04
S 32 4
S 34 81
S 39 80
S 33 1
E 10 10 8 f00
E 18 10 4 0f0
E 34 14 4 00f
E 20 9 1 ff0
I 14
F
R 2 1
E 10 10 4 0ff
E 14 10 4 f00
E 18 10 4 0f0
E 34 14 4 00f
E 20 9 1 ff0
I 14
F
R 1 0
I 14
F
R 0 0
R 1 1
E 10 10 8 f00
E 18 10 4 0f0
E 34 14 4 00f
E 20 9 1 ff0
I 14
F

// ==== sim.f ====
+incdir+test
rtl/video_pkg.sv
rtl/video_timing.sv
rtl/text_layer.sv
rtl/sprite_store.sv
rtl/sprite_engine.sv
rtl/compositor.sv
rtl/video.sv
test/video_tb.sv
